// ==== daq_settings.svh ====
`ifndef DAQ_SETTINGS_SVH
`define DAQ_SETTINGS_SVH

// one dac sample, unsigned, wraps mod 2^16
`define DAQ_SAMPLE_WIDTH 16
// segment length field in samples
`define DAQ_DUR_WIDTH 16

// samples per dac batch
`define DAQ_BATCH_SAMPLES 4

// dma beat: start [15:0], slope [31:16], dur [47:32]
`define DAQ_DMA_WIDTH 48

// register port widths
`define DAQ_ADDR_WIDTH 8
`define DAQ_REG_WIDTH 32
`define DAQ_RESP_WIDTH 2

// register map
// bit 0 is run
`define DAQ_ADDR_CTRL 0
// low 16 bits hold the sample offset
`define DAQ_ADDR_OFFSET 4

`endif

// ==== daq_pkg.sv ====
`default_nettype none

`include "daq_settings.svh"

package daq_pkg;

    // sample path types
    typedef logic [`DAQ_SAMPLE_WIDTH-1:0] sample_t;
    // per-sample step, added mod 2^16
    typedef logic [`DAQ_SAMPLE_WIDTH-1:0] slope_t;
    typedef logic [`DAQ_DUR_WIDTH-1:0] dur_t;

    // sample 0 sits in the low bits
    typedef sample_t [`DAQ_BATCH_SAMPLES-1:0] batch_t;

    // register port types
    typedef logic [`DAQ_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [`DAQ_REG_WIDTH-1:0] reg_data_t;
    typedef logic [`DAQ_RESP_WIDTH-1:0] resp_t;

    // axi style response codes
    localparam resp_t RESP_OKAY = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;

    // one pwl segment as held between unpack and interp
    typedef struct packed {
        sample_t start;
        slope_t  slope;
        dur_t    dur;
        logic    last;
    } segment_t;

    // raw dma beat layout, msb first
    typedef struct packed {
        dur_t    dur;
        slope_t  slope;
        sample_t start;
    } dma_beat_t;

endpackage

`default_nettype wire

// ==== ps_reg_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "daq_settings.svh"

module ps_reg_decode (
    input  wire                     dac_clk,
    input  wire                     rst,
    input  wire daq_pkg::reg_addr_t waddr,
    input  wire                     waddr_valid,
    input  wire daq_pkg::reg_data_t wdata,
    input  wire                     wdata_valid,
    input  wire daq_pkg::reg_addr_t raddr,
    input  wire                     raddr_valid,
    output daq_pkg::resp_t          wresp,
    output logic                    wresp_valid,
    output daq_pkg::reg_data_t      rdata,
    output daq_pkg::resp_t          rresp,
    output logic                    rdata_valid,
    output logic                    run,
    output daq_pkg::sample_t        offset
);

    // write only when address and data strobe together
    logic wr_fire;
    logic wr_ctrl;
    logic wr_offset;
    logic rd_known;
    daq_pkg::reg_data_t rd_value;

    assign wr_fire   = waddr_valid && wdata_valid;
    assign wr_ctrl   = (waddr == daq_pkg::reg_addr_t'(`DAQ_ADDR_CTRL));
    assign wr_offset = (waddr == daq_pkg::reg_addr_t'(`DAQ_ADDR_OFFSET));

    // read mux, unknown address reads zero
    always_comb begin
        rd_known = 1'b1;
        case (raddr)
            daq_pkg::reg_addr_t'(`DAQ_ADDR_CTRL):   rd_value = daq_pkg::reg_data_t'(run);
            daq_pkg::reg_addr_t'(`DAQ_ADDR_OFFSET): rd_value = daq_pkg::reg_data_t'(offset);
            default: begin
                rd_value = '0;
                rd_known = 1'b0;
            end
        endcase
    end

    // control regs and one-cycle response pulses
    always_ff @(posedge dac_clk) begin
        if (rst) begin
            run         <= 1'b0;
            offset      <= '0;
            wresp_valid <= 1'b0;
            rdata_valid <= 1'b0;
        end else begin
            wresp_valid <= wr_fire;
            rdata_valid <= raddr_valid;
            // unknown address leaves both regs alone
            if (wr_fire && wr_ctrl) begin
                run <= wdata[0];
            end
            if (wr_fire && wr_offset) begin
                offset <= wdata[`DAQ_SAMPLE_WIDTH-1:0];
            end
        end
    end

    // response payload, only meaningful with its valid
    always_ff @(posedge dac_clk) begin
        if (wr_fire) begin
            wresp <= (wr_ctrl || wr_offset) ? daq_pkg::RESP_OKAY : daq_pkg::RESP_SLVERR;
        end
        if (raddr_valid) begin
            rdata <= rd_value;
            rresp <= rd_known ? daq_pkg::RESP_OKAY : daq_pkg::RESP_SLVERR;
        end
    end

endmodule

`default_nettype wire

// ==== pwl_unpack.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "daq_settings.svh"

module pwl_unpack (
    input  wire                      dac_clk,
    input  wire                      rst,
    input  wire                      run,
    input  wire [`DAQ_DMA_WIDTH-1:0] pwl_tdata,
    input  wire                      pwl_tvalid,
    input  wire                      pwl_tlast,
    input  wire                      seg_ready,
    output logic                     pwl_tready,
    output daq_pkg::segment_t        seg,
    output logic                     seg_valid
);

    daq_pkg::dma_beat_t beat;
    logic beat_fire;

    // slice the beat into its three fields
    assign beat = daq_pkg::dma_beat_t'(pwl_tdata);

    // take a beat if empty, or if the held segment leaves this cycle
    // run low blocks new beats, the held one still drains
    assign pwl_tready = run && (!seg_valid || seg_ready);
    assign beat_fire  = pwl_tvalid && pwl_tready;

    // occupancy flag
    always_ff @(posedge dac_clk) begin
        if (rst) begin
            seg_valid <= 1'b0;
        end else if (beat_fire) begin
            seg_valid <= 1'b1;
        end else if (seg_ready) begin
            seg_valid <= 1'b0;
        end
    end

    // segment payload
    // tlast marks the final segment of a waveform
    always_ff @(posedge dac_clk) begin
        if (beat_fire) begin
            seg.start <= beat.start;
            seg.slope <= beat.slope;
            seg.dur   <= beat.dur;
            seg.last  <= pwl_tlast;
        end
    end

endmodule

`default_nettype wire

// ==== pwl_interp.sv ====
`timescale 1ns/1ns
`default_nettype none

module pwl_interp (
    input  wire                    dac_clk,
    input  wire                    rst,
    input  wire daq_pkg::segment_t seg,
    input  wire                    seg_valid,
    input  wire daq_pkg::sample_t  offset,
    input  wire                    samp_ready,
    output logic                   seg_ready,
    output daq_pkg::sample_t       samp,
    output logic                   samp_valid,
    output logic                   samp_last
);

    typedef enum logic {IDLE, RUN} interp_state_t;

    interp_state_t state;
    // running value without offset
    daq_pkg::sample_t acc;
    daq_pkg::slope_t slope_q;
    // samples left including the one on the output
    daq_pkg::dur_t remain;
    logic last_q;

    logic final_samp;
    logic need_next;
    logic skip_zero;
    logic seg_fire;
    logic samp_fire;
    logic load_seg;
    logic advance;

    assign final_samp = (state == RUN) && (remain == daq_pkg::dur_t'(1));
    // final sample of an open waveform waits to see what follows
    // so a zero-length terminator can still flag it as last
    assign need_next  = final_samp && !last_q;
    // zero-length mid-waveform segments are dropped on sight
    assign skip_zero  = seg_valid && (seg.dur == '0) && !seg.last;

    always_comb begin
        if (state == IDLE) begin
            seg_ready = 1'b1;
        end else begin
            seg_ready = final_samp && (samp_ready || (!last_q && skip_zero));
        end
    end

    assign samp_valid = (state == RUN) && (!need_next || (seg_valid && !skip_zero));
    assign samp_last  = final_samp && (last_q || (seg_valid && (seg.dur == '0) && seg.last));
    assign samp       = acc + offset;

    assign seg_fire  = seg_valid && seg_ready;
    assign samp_fire = samp_valid && samp_ready;
    // next segment loads on the final accept, back to back
    assign load_seg  = seg_fire && (seg.dur != '0);
    assign advance   = samp_fire && !final_samp;

    // fsm
    always_ff @(posedge dac_clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (load_seg) begin
                        state <= RUN;
                    end
                end
                RUN: begin
                    if (samp_fire && final_samp && !load_seg) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // accumulator and counter
    always_ff @(posedge dac_clk) begin
        if (load_seg) begin
            acc     <= seg.start;
            slope_q <= seg.slope;
            remain  <= seg.dur;
            last_q  <= seg.last;
        end else if (advance) begin
            // wraps mod 2^16, negative slope is two's complement
            acc    <= acc + slope_q;
            remain <= remain - daq_pkg::dur_t'(1);
        end
    end

endmodule

`default_nettype wire

// ==== batch_pack.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "daq_settings.svh"

module batch_pack (
    input  wire                   dac_clk,
    input  wire                   rst,
    input  wire daq_pkg::sample_t samp,
    input  wire                   samp_valid,
    input  wire                   samp_last,
    input  wire                   dac_rdy,
    output logic                  samp_ready,
    output daq_pkg::batch_t       dac_batch,
    output logic                  dac_batch_valid
);

    localparam int CNT_W = $clog2(`DAQ_BATCH_SAMPLES);

    // next slot to fill
    logic [CNT_W-1:0] slot;
    logic samp_fire;
    logic batch_done;

    // held batch blocks input until the dac takes it
    assign samp_ready = !dac_batch_valid || dac_rdy;
    assign samp_fire  = samp_valid && samp_ready;
    assign batch_done = samp_last || (slot == CNT_W'(`DAQ_BATCH_SAMPLES - 1));

    // slot count and batch valid
    always_ff @(posedge dac_clk) begin
        if (rst) begin
            slot            <= '0;
            dac_batch_valid <= 1'b0;
        end else begin
            if (dac_batch_valid && dac_rdy) begin
                dac_batch_valid <= 1'b0;
            end
            if (samp_fire) begin
                if (batch_done) begin
                    slot            <= '0;
                    dac_batch_valid <= 1'b1;
                end else begin
                    slot <= slot + CNT_W'(1);
                end
            end
        end
    end

    // slot writes
    // a last sample also fills every slot above it as padding
    always_ff @(posedge dac_clk) begin
        if (samp_fire) begin
            for (int i = 0; i < `DAQ_BATCH_SAMPLES; i++) begin
                if ((slot == CNT_W'(i)) || (samp_last && (CNT_W'(i) > slot))) begin
                    dac_batch[i] <= samp;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== dac_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "daq_settings.svh"

module dac_top (
    input  wire                      dac_clk,
    input  wire                      rst,
    // register port
    input  wire daq_pkg::reg_addr_t  waddr,
    input  wire                      waddr_valid,
    input  wire daq_pkg::reg_data_t  wdata,
    input  wire                      wdata_valid,
    input  wire daq_pkg::reg_addr_t  raddr,
    input  wire                      raddr_valid,
    output daq_pkg::resp_t           wresp,
    output logic                     wresp_valid,
    output daq_pkg::reg_data_t       rdata,
    output daq_pkg::resp_t           rresp,
    output logic                     rdata_valid,
    // dma segment stream
    input  wire [`DAQ_DMA_WIDTH-1:0] pwl_tdata,
    input  wire                      pwl_tvalid,
    input  wire                      pwl_tlast,
    output logic                     pwl_tready,
    // dac batch port
    input  wire                      dac_rdy,
    output daq_pkg::batch_t          dac_batch,
    output logic                     dac_batch_valid
);

    // register levels into the pipeline
    logic run;
    daq_pkg::sample_t offset;

    // unpack to interp
    daq_pkg::segment_t seg;
    logic seg_valid;
    logic seg_ready;

    // interp to packer
    daq_pkg::sample_t samp;
    logic samp_valid;
    logic samp_last;
    logic samp_ready;

    ps_reg_decode reg_decode_inst (
        .dac_clk(dac_clk), .rst(rst),
        .waddr(waddr), .waddr_valid(waddr_valid),
        .wdata(wdata), .wdata_valid(wdata_valid),
        .raddr(raddr), .raddr_valid(raddr_valid),
        .wresp(wresp), .wresp_valid(wresp_valid),
        .rdata(rdata), .rresp(rresp), .rdata_valid(rdata_valid),
        .run(run), .offset(offset)
    );

    pwl_unpack unpack_inst (
        .dac_clk(dac_clk), .rst(rst), .run(run),
        .pwl_tdata(pwl_tdata), .pwl_tvalid(pwl_tvalid), .pwl_tlast(pwl_tlast),
        .seg_ready(seg_ready), .pwl_tready(pwl_tready),
        .seg(seg), .seg_valid(seg_valid)
    );

    pwl_interp interp_inst (
        .dac_clk(dac_clk), .rst(rst),
        .seg(seg), .seg_valid(seg_valid), .offset(offset),
        .samp_ready(samp_ready), .seg_ready(seg_ready),
        .samp(samp), .samp_valid(samp_valid), .samp_last(samp_last)
    );

    batch_pack pack_inst (
        .dac_clk(dac_clk), .rst(rst),
        .samp(samp), .samp_valid(samp_valid), .samp_last(samp_last),
        .dac_rdy(dac_rdy), .samp_ready(samp_ready),
        .dac_batch(dac_batch), .dac_batch_valid(dac_batch_valid)
    );

endmodule

`default_nettype wire

// ==== dac_top_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "daq_settings.svh"

module dac_top_tb;

    logic dac_clk;
    logic rst;
    daq_pkg::reg_addr_t waddr;
    logic waddr_valid;
    daq_pkg::reg_data_t wdata;
    logic wdata_valid;
    daq_pkg::reg_addr_t raddr;
    logic raddr_valid;
    daq_pkg::resp_t wresp;
    logic wresp_valid;
    daq_pkg::reg_data_t rdata;
    daq_pkg::resp_t rresp;
    logic rdata_valid;
    logic [`DAQ_DMA_WIDTH-1:0] pwl_tdata;
    logic pwl_tvalid;
    logic pwl_tlast;
    logic pwl_tready;
    logic dac_rdy;
    daq_pkg::batch_t dac_batch;
    logic dac_batch_valid;

    // beats still to send plus expected and collected batches
    daq_pkg::segment_t beat_q[$];
    daq_pkg::batch_t exp_q[$];
    daq_pkg::batch_t got_q[$];
    string test_name = "startup";
    int cycle_count = 0;
    int cycle_limit = 0;

    dac_top dac_top_inst (
        .dac_clk(dac_clk), .rst(rst),
        .waddr(waddr), .waddr_valid(waddr_valid),
        .wdata(wdata), .wdata_valid(wdata_valid),
        .raddr(raddr), .raddr_valid(raddr_valid),
        .wresp(wresp), .wresp_valid(wresp_valid),
        .rdata(rdata), .rresp(rresp), .rdata_valid(rdata_valid),
        .pwl_tdata(pwl_tdata), .pwl_tvalid(pwl_tvalid), .pwl_tlast(pwl_tlast),
        .pwl_tready(pwl_tready),
        .dac_rdy(dac_rdy), .dac_batch(dac_batch), .dac_batch_valid(dac_batch_valid)
    );

    // 10 ns clock
    initial begin
        dac_clk = 1'b0;
        forever #5 dac_clk = ~dac_clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_resp(input string what, input daq_pkg::resp_t exp,
                              input daq_pkg::resp_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("error %s %s expected %0d actual %0d",
                                    test_name, what, exp, act));
        end
    endtask

    task automatic check_reg(input string what, input daq_pkg::reg_data_t exp,
                             input daq_pkg::reg_data_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("error %s %s expected %h actual %h",
                                    test_name, what, exp, act));
        end
    endtask

    task automatic check_batch(input int idx, input daq_pkg::batch_t exp,
                               input daq_pkg::batch_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("error %s batch %0d expected %h actual %h",
                                    test_name, idx, exp, act));
        end
    endtask

    // strobe for one cycle and expect the response pulse one cycle later
    task automatic reg_write(input daq_pkg::reg_addr_t a, input daq_pkg::reg_data_t d,
                             input daq_pkg::resp_t exp_resp);
        @(posedge dac_clk);
        waddr <= a;
        wdata <= d;
        waddr_valid <= 1'b1;
        wdata_valid <= 1'b1;
        @(negedge dac_clk);
        if (wresp_valid) stop_on_error("write response came before the write strobe was taken");
        @(posedge dac_clk);
        waddr_valid <= 1'b0;
        wdata_valid <= 1'b0;
        @(negedge dac_clk);
        if (!wresp_valid) stop_on_error("no write response one cycle after the write strobe");
        check_resp("write resp", exp_resp, wresp);
        @(negedge dac_clk);
        if (wresp_valid) stop_on_error("write response stayed high for more than one cycle");
    endtask

    task automatic reg_read(input daq_pkg::reg_addr_t a, input daq_pkg::reg_data_t exp_data,
                            input daq_pkg::resp_t exp_resp);
        @(posedge dac_clk);
        raddr <= a;
        raddr_valid <= 1'b1;
        @(negedge dac_clk);
        if (rdata_valid) stop_on_error("read data came before the read strobe was taken");
        @(posedge dac_clk);
        raddr_valid <= 1'b0;
        @(negedge dac_clk);
        if (!rdata_valid) stop_on_error("no read data one cycle after the read strobe");
        check_reg("read data", exp_data, rdata);
        check_resp("read resp", exp_resp, rresp);
        @(negedge dac_clk);
        if (rdata_valid) stop_on_error("read data valid stayed high for more than one cycle");
    endtask

    // offer the first queued beat while run is low and make sure it is refused
    task automatic hold_while_stopped(input int cycles);
        daq_pkg::segment_t s;
        s = beat_q[0];
        @(posedge dac_clk);
        pwl_tdata <= {s.dur, s.slope, s.start};
        pwl_tlast <= s.last;
        pwl_tvalid <= 1'b1;
        repeat (cycles) begin
            @(negedge dac_clk);
            if (pwl_tready) stop_on_error("pwl_tready went high while run was low");
            if (got_q.size() != 0) stop_on_error("a batch appeared while run was low");
        end
        @(posedge dac_clk);
        pwl_tvalid <= 1'b0;
    endtask

    // beats go out with random gaps and tready is sampled mid cycle
    task automatic send_beats();
        daq_pkg::segment_t s;
        int gap;
        @(posedge dac_clk);
        while (beat_q.size() > 0) begin
            s = beat_q.pop_front();
            gap = $urandom_range(0, 3);
            if (gap > 0) begin
                pwl_tvalid <= 1'b0;
                repeat (gap) @(posedge dac_clk);
            end
            pwl_tdata <= {s.dur, s.slope, s.start};
            pwl_tlast <= s.last;
            pwl_tvalid <= 1'b1;
            @(negedge dac_clk);
            while (!pwl_tready) @(negedge dac_clk);
            // beat is taken on this edge
            @(posedge dac_clk);
        end
        pwl_tvalid <= 1'b0;
    endtask

    // wait for every expected batch then compare in order
    task automatic stream_waveform();
        int n;
        n = exp_q.size();
        send_beats();
        while (got_q.size() < n) @(negedge dac_clk);
        for (int i = 0; i < n; i++) begin
            check_batch(i, exp_q.pop_front(), got_q.pop_front());
        end
    endtask

    // sum of segment lengths in the stimulus
    task automatic count_samples(output int total);
        int fd;
        int rc;
        string line;
        byte kind;
        logic [31:0] f_a, f_b, f_c, f_d;
        total = 0;
        fd = $fopen("dac_stimulus.txt", "r");
        while (fd != 0 && !$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc > 1 && line.getc(0) == "S") begin
                rc = $sscanf(line, "%c %h %h %h %h", kind, f_a, f_b, f_c, f_d);
                total += f_c;
            end
        end
        if (fd != 0) $fclose(fd);
    endtask

    // dac side takes a batch about every other cycle
    always @(posedge dac_clk) begin
        if (rst) begin
            dac_rdy <= 1'b0;
        end else begin
            dac_rdy <= $urandom_range(0, 1);
        end
    end

    // a batch seen here transfers on the next rising edge
    always @(negedge dac_clk) begin
        if (!rst && dac_batch_valid && dac_rdy) begin
            got_q.push_back(dac_batch);
        end
    end

    // run limit scales with the sample count
    always @(posedge dac_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            stop_on_error($sformatf("timeout, batch stream stalled after %0d cycles",
                                    cycle_count));
        end
    end

    initial begin : main
        int fd;
        int rc;
        int total;
        string line;
        byte kind;
        logic [31:0] f_a, f_b, f_c, f_d;
        daq_pkg::segment_t s;
        daq_pkg::batch_t b;
        rc = $urandom(32'h3d48_6590);
        rst = 1'b1;
        waddr = '0;
        waddr_valid = 1'b0;
        wdata = '0;
        wdata_valid = 1'b0;
        raddr = '0;
        raddr_valid = 1'b0;
        pwl_tdata = '0;
        pwl_tvalid = 1'b0;
        pwl_tlast = 1'b0;
        dac_rdy = 1'b0;
        count_samples(total);
        cycle_limit = 20 * total + 200;
        repeat (10) @(posedge dac_clk);
        rst <= 1'b0;
        fd = $fopen("dac_stimulus.txt", "r");
        if (fd == 0) stop_on_error("could not open dac_stimulus.txt");
        while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc > 1) begin
                kind = line.getc(0);
                case (kind)
                    "T": rc = $sscanf(line, "%c %s", kind, test_name);
                    "W": begin
                        rc = $sscanf(line, "%c %h %h %h", kind, f_a, f_b, f_c);
                        reg_write(daq_pkg::reg_addr_t'(f_a), f_b, daq_pkg::resp_t'(f_c));
                    end
                    "R": begin
                        rc = $sscanf(line, "%c %h %h %h", kind, f_a, f_b, f_c);
                        reg_read(daq_pkg::reg_addr_t'(f_a), f_b, daq_pkg::resp_t'(f_c));
                    end
                    "S": begin
                        rc = $sscanf(line, "%c %h %h %h %h", kind, f_a, f_b, f_c, f_d);
                        s.start = daq_pkg::sample_t'(f_a);
                        s.slope = daq_pkg::slope_t'(f_b);
                        s.dur   = daq_pkg::dur_t'(f_c);
                        s.last  = f_d[0];
                        beat_q.push_back(s);
                    end
                    "B": begin
                        rc = $sscanf(line, "%c %h %h %h %h", kind, f_a, f_b, f_c, f_d);
                        b[0] = daq_pkg::sample_t'(f_a);
                        b[1] = daq_pkg::sample_t'(f_b);
                        b[2] = daq_pkg::sample_t'(f_c);
                        b[3] = daq_pkg::sample_t'(f_d);
                        exp_q.push_back(b);
                    end
                    "H": begin
                        rc = $sscanf(line, "%c %h", kind, f_a);
                        hold_while_stopped(f_a);
                    end
                    "E": stream_waveform();
                    default: ;
                endcase
            end
        end
        $fclose(fd);
        // anything arriving now would be a duplicate
        repeat (20) @(negedge dac_clk);
        if (got_q.size() != 0 || exp_q.size() != 0 || beat_q.size() != 0) begin
            stop_on_error($sformatf("%0d batches and %0d beats left over at the end of the run",
                                    got_q.size() + exp_q.size(), beat_q.size()));
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== dac_stimulus.txt ====
# T name | W addr data resp | R addr data resp | S start slope dur last
# B s0 s1 s2 s3 | H cycles with run low | E stream beats and match batches, values in hex
T reg_access
W 04 00000010 0
R 04 00000010 0
W 00 00000001 0
R 00 00000001 0
W 08 12345678 2
R 08 00000000 2
R 04 00000010 0
T pwl_partial_batch
S 0100 0010 3 0
S 0000 0000 0 0
S 0200 fff0 5 0
S fff8 0004 3 1
B 0110 0120 0130 0210
B 0200 01f0 01e0 01d0
B 0008 000c 0010 0010
E
T run_gating_offset
W 00 00000000 0
R 00 00000000 0
W 04 00001000 0
R 04 00001000 0
S 0000 0100 6 0
S 8000 8000 3 0
S 0000 0000 0 1
H 14
W 00 00000001 0
B 1000 1100 1200 1300
B 1400 1500 9000 1000
B 9000 9000 9000 9000
E

// ==== all.f ====
+incdir+.
daq_pkg.sv
ps_reg_decode.sv
pwl_unpack.sv
pwl_interp.sv
batch_pack.sv
dac_top.sv
dac_top_tb.sv
